// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for a failure
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
	--top-module mem_system_tb -o mem_system_sim \
	&& ./obj_dir/mem_system_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0

// ==== source/cache_controller.sv ====
`timescale 1ns/100ps

module cache_controller (
	input logic clk,
	input logic reset,
	input mem_system_pkg::addr_t addr,
	input mem_system_pkg::word_t data_in,
	input logic rd,
	input logic wr,
	input logic hit,
	input mem_system_pkg::word_t hit_data,
	input mem_system_pkg::way_mask_t way_valid,
	input mem_system_pkg::way_mask_t way_dirty,
	input mem_system_pkg::tag_t victim_tag,
	input mem_system_pkg::word_t victim_data,
	input mem_system_pkg::word_t mem_rdata,
	cache_if.ctrl ways [mem_system_pkg::NUM_WAYS],
	output mem_system_pkg::way_mask_t chosen_way,
	output mem_system_pkg::addr_t mem_addr,
	output mem_system_pkg::word_t mem_wdata,
	output logic mem_wr,
	output logic mem_rd,
	output mem_system_pkg::word_t data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err
);

	mem_system_pkg::ctrl_state_t state, next_state;
	mem_system_pkg::addr_t req_addr;
	mem_system_pkg::word_t req_data;
	logic req_wr;
	logic victim; // Replacement pointer
	logic victim_toggle;
	mem_system_pkg::way_mask_t pick;
	mem_system_pkg::way_mask_t way_en;
	logic cmd_comp;
	logic cmd_write;
	logic cmd_fill;
	mem_system_pkg::word_t cmd_data;
	logic [1:0] way_word; // Word addressed in the ways
	logic [1:0] mem_word; // Word addressed in memory
	logic mem_from_victim;
	mem_system_pkg::tag_t req_tag;
	mem_system_pkg::index_t req_index;

	assign req_tag = req_addr[15:11];
	assign req_index = req_addr[10:3];

	for (genvar g = 0; g < mem_system_pkg::NUM_WAYS; g++) begin : g_cmd
		assign ways[g].enable = way_en[g];
		assign ways[g].index = req_index;
		assign ways[g].offset = {way_word, 1'b0};
		assign ways[g].tag_in = req_tag;
		assign ways[g].comp = cmd_comp;
		assign ways[g].write = cmd_write;
		assign ways[g].write_data = cmd_data;
		assign ways[g].fill = cmd_fill;
	end

	// First invalid way wins over the victim pointer
	always_comb begin
		pick = victim ? 2'b10 : 2'b01;
		for (int i = mem_system_pkg::NUM_WAYS - 1; i >= 0; i--) begin
			if (!way_valid[i]) begin
				pick = mem_system_pkg::way_mask_t'(1) << i;
			end
		end
	end

	assign mem_addr = {mem_from_victim ? victim_tag : req_tag, req_index, mem_word, 1'b0};
	assign mem_wdata = victim_data;
	assign data_out = hit_data;
	assign stall = (state != mem_system_pkg::idle);

	always_comb begin
		next_state = state;
		way_en = '0;
		cmd_comp = 1'b0;
		cmd_write = 1'b0;
		cmd_fill = 1'b0;
		cmd_data = req_data;
		way_word = req_addr[2:1];
		mem_word = 2'd0;
		mem_from_victim = 1'b0;
		mem_wr = 1'b0;
		mem_rd = 1'b0;
		done = 1'b0;
		cache_hit = 1'b0;
		err = 1'b0;
		victim_toggle = 1'b0;
		case (state)
			mem_system_pkg::idle: begin
				if (rd || wr) next_state = mem_system_pkg::compare;
			end
			mem_system_pkg::compare: begin
				if (req_addr[0]) begin
					err = 1'b1; // Odd address leaves the cache untouched
					done = 1'b1;
					next_state = mem_system_pkg::idle;
				end else begin
					way_en = '1;
					cmd_comp = 1'b1;
					cmd_write = req_wr;
					victim_toggle = 1'b1;
					if (hit) begin
						done = 1'b1;
						cache_hit = 1'b1;
						next_state = mem_system_pkg::idle;
					end else begin
						next_state = mem_system_pkg::choose_way;
					end
				end
			end
			mem_system_pkg::choose_way: begin
				way_en = '1; // Read valid and dirty of the set
				if (|(pick & way_valid & way_dirty)) next_state = mem_system_pkg::wb_0;
				else next_state = mem_system_pkg::req_0;
			end
			mem_system_pkg::wb_0, mem_system_pkg::wb_1,
			mem_system_pkg::wb_2, mem_system_pkg::wb_3: begin
				way_en = chosen_way;
				way_word = 2'(state - mem_system_pkg::wb_0);
				mem_word = way_word;
				mem_from_victim = 1'b1;
				mem_wr = 1'b1;
				next_state = mem_system_pkg::ctrl_state_t'(state + 1'b1);
			end
			mem_system_pkg::req_0, mem_system_pkg::req_1: begin
				mem_rd = 1'b1;
				mem_word = 2'(state - mem_system_pkg::req_0);
				next_state = mem_system_pkg::ctrl_state_t'(state + 1'b1);
			end
			mem_system_pkg::fill_0, mem_system_pkg::fill_1,
			mem_system_pkg::fill_2, mem_system_pkg::fill_3: begin
				way_en = chosen_way;
				cmd_write = 1'b1;
				cmd_data = mem_rdata; // Word read two cycles earlier
				way_word = 2'(state - mem_system_pkg::fill_0);
				mem_rd = !way_word[1]; // Last two reads overlap fills
				mem_word = way_word + 2'd2;
				cmd_fill = (state == mem_system_pkg::fill_3);
				next_state = mem_system_pkg::ctrl_state_t'(state + 1'b1);
			end
			mem_system_pkg::finish: begin
				way_en = '1;
				cmd_comp = 1'b1;
				cmd_write = req_wr;
				done = 1'b1;
				next_state = mem_system_pkg::idle;
			end
			default: begin
				err = 1'b1;
				done = 1'b1;
				next_state = mem_system_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mem_system_pkg::idle;
			victim <= 1'b0;
			chosen_way <= '0;
		end else begin
			state <= next_state;
			if (victim_toggle) victim <= ~victim;
			if (state == mem_system_pkg::choose_way) chosen_way <= pick;
		end
	end

	// Request registers load on acceptance
	always_ff @(posedge clk) begin
		if (state == mem_system_pkg::idle && (rd || wr)) begin
			req_addr <= addr;
			req_data <= data_in;
			req_wr <= wr;
		end
	end

endmodule

// ==== source/cache_if.sv ====
`timescale 1ns/100ps

interface cache_if;

	logic enable; // Way takes part in this access
	mem_system_pkg::index_t index;
	mem_system_pkg::offset_t offset;
	mem_system_pkg::tag_t tag_in;
	logic comp; // Compare mode
	logic write;
	mem_system_pkg::word_t write_data;
	logic fill; // Last word of a refill

	logic tag_match;
	logic valid;
	logic dirty;
	mem_system_pkg::tag_t tag_out;
	mem_system_pkg::word_t read_data;

	modport ctrl (
		output enable, index, offset, tag_in, comp, write, write_data, fill
	);

	modport way (
		input enable, index, offset, tag_in, comp, write, write_data, fill,
		output tag_match, valid, dirty, tag_out, read_data
	);

	modport sel (
		input tag_match, valid, dirty, tag_out, read_data
	);

endinterface

// ==== source/cache_way.sv ====
`timescale 1ns/100ps

module cache_way (
	input logic clk,
	input logic reset,
	cache_if.way port
);

	mem_system_pkg::tag_t tag_mem [mem_system_pkg::NUM_SETS];
	mem_system_pkg::word_t data_mem [mem_system_pkg::NUM_SETS][mem_system_pkg::WORDS_PER_BLOCK];
	logic [mem_system_pkg::NUM_SETS-1:0] valid_bits;
	logic [mem_system_pkg::NUM_SETS-1:0] dirty_bits;
	logic [1:0] word_sel; // Word inside the block
	logic line_hit;
	logic do_write;

	assign word_sel = port.offset[2:1];
	assign do_write = port.enable && port.write;

	// Status is only presented for an enabled way
	assign port.tag_out = port.enable ? tag_mem[port.index] : '0;
	assign port.tag_match = port.enable && (tag_mem[port.index] == port.tag_in);
	assign port.valid = port.enable && valid_bits[port.index];
	assign port.dirty = port.enable && dirty_bits[port.index];
	assign port.read_data = port.enable ? data_mem[port.index][word_sel] : '0;

	assign line_hit = port.tag_match && port.valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (do_write) begin
			if (port.comp) begin
				if (line_hit) begin
					dirty_bits[port.index] <= 1'b1; // Store hit marks the line
				end
			end else if (port.fill) begin
				valid_bits[port.index] <= 1'b1; // Block complete
				dirty_bits[port.index] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_write) begin
			if (port.comp) begin
				if (line_hit) begin
					data_mem[port.index][word_sel] <= port.write_data;
				end
			end else begin
				// Refill writes the word and takes the new tag
				data_mem[port.index][word_sel] <= port.write_data;
				tag_mem[port.index] <= port.tag_in;
			end
		end
	end

endmodule

// ==== source/main_memory.sv ====
`timescale 1ns/100ps

module main_memory (
	input logic clk,
	input logic reset,
	input mem_system_pkg::addr_t addr,
	input mem_system_pkg::word_t wdata,
	input logic wr,
	input logic rd,
	output mem_system_pkg::word_t rdata
);

	mem_system_pkg::word_t mem [mem_system_pkg::MEM_WORDS];
	mem_system_pkg::word_t rd_pipe [mem_system_pkg::MEM_READ_LATENCY];
	logic [14:0] word_addr;

	assign word_addr = addr[15:1]; // Byte address to word address

	initial begin
		for (int i = 0; i < mem_system_pkg::MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[word_addr] <= wdata;
		end
	end

	// Each stage shifts every cycle so two reads can be in flight
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < mem_system_pkg::MEM_READ_LATENCY; i++) begin
				rd_pipe[i] <= '0;
			end
		end else begin
			rd_pipe[0] <= rd ? mem[word_addr] : '0;
			for (int i = 1; i < mem_system_pkg::MEM_READ_LATENCY; i++) begin
				rd_pipe[i] <= rd_pipe[i-1];
			end
		end
	end

	assign rdata = rd_pipe[mem_system_pkg::MEM_READ_LATENCY-1];

endmodule

// ==== source/mem_system.sv ====
`timescale 1ns/100ps

module mem_system (
	input logic clk,
	input logic reset,
	input mem_system_pkg::addr_t addr,
	input mem_system_pkg::word_t data_in,
	input logic rd,
	input logic wr,
	output mem_system_pkg::word_t data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err
);

	cache_if ways [mem_system_pkg::NUM_WAYS] ();

	logic hit;
	mem_system_pkg::word_t hit_data;
	mem_system_pkg::way_mask_t way_valid;
	mem_system_pkg::way_mask_t way_dirty;
	mem_system_pkg::tag_t victim_tag;
	mem_system_pkg::word_t victim_data;
	mem_system_pkg::way_mask_t chosen_way;
	mem_system_pkg::addr_t mem_addr;
	mem_system_pkg::word_t mem_wdata;
	mem_system_pkg::word_t mem_rdata;
	logic mem_wr;
	logic mem_rd;

	cache_controller u_controller (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.hit(hit),
		.hit_data(hit_data),
		.way_valid(way_valid),
		.way_dirty(way_dirty),
		.victim_tag(victim_tag),
		.victim_data(victim_data),
		.mem_rdata(mem_rdata),
		.ways(ways),
		.chosen_way(chosen_way),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wr(mem_wr),
		.mem_rd(mem_rd),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err)
	);

	for (genvar g = 0; g < mem_system_pkg::NUM_WAYS; g++) begin : g_way
		cache_way u_way (
			.clk(clk),
			.reset(reset),
			.port(ways[g])
		);
	end

	way_select u_select (
		.ways(ways),
		.chosen_way(chosen_way),
		.hit(hit),
		.hit_data(hit_data),
		.way_valid(way_valid),
		.way_dirty(way_dirty),
		.victim_tag(victim_tag),
		.victim_data(victim_data)
	);

	main_memory u_memory (
		.clk(clk),
		.reset(reset),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.wr(mem_wr),
		.rd(mem_rd),
		.rdata(mem_rdata)
	);

endmodule

// ==== source/mem_system_pkg.sv ====
package mem_system_pkg;

	localparam int NUM_WAYS = 2;
	localparam int WORDS_PER_BLOCK = 4;
	localparam int NUM_SETS = 256;
	localparam int MEM_READ_LATENCY = 2;
	localparam int MEM_WORDS = 32768; // One word per even byte address

	typedef logic [15:0] addr_t; // Byte address
	typedef logic [15:0] word_t;
	typedef logic [4:0] tag_t; // Address bits 15 to 11
	typedef logic [7:0] index_t; // Address bits 10 to 3
	typedef logic [2:0] offset_t; // Byte offset inside a block
	typedef logic [NUM_WAYS-1:0] way_mask_t;

	typedef enum logic [3:0] {
		idle,
		compare,
		choose_way,
		wb_0,
		wb_1,
		wb_2,
		wb_3,
		req_0,
		req_1,
		fill_0,
		fill_1,
		fill_2,
		fill_3,
		finish
	} ctrl_state_t;

endpackage

// ==== source/way_select.sv ====
`timescale 1ns/100ps

module way_select (
	cache_if.sel ways [mem_system_pkg::NUM_WAYS],
	input mem_system_pkg::way_mask_t chosen_way,
	output logic hit,
	output mem_system_pkg::word_t hit_data,
	output mem_system_pkg::way_mask_t way_valid,
	output mem_system_pkg::way_mask_t way_dirty,
	output mem_system_pkg::tag_t victim_tag,
	output mem_system_pkg::word_t victim_data
);

	mem_system_pkg::way_mask_t match;
	mem_system_pkg::way_mask_t hit_mask;
	mem_system_pkg::tag_t tags [mem_system_pkg::NUM_WAYS];
	mem_system_pkg::word_t words [mem_system_pkg::NUM_WAYS];

	for (genvar g = 0; g < mem_system_pkg::NUM_WAYS; g++) begin : g_gather
		assign match[g] = ways[g].tag_match;
		assign way_valid[g] = ways[g].valid;
		assign way_dirty[g] = ways[g].dirty;
		assign tags[g] = ways[g].tag_out;
		assign words[g] = ways[g].read_data;
	end

	assign hit_mask = match & way_valid;
	assign hit = |hit_mask;

	always_comb begin
		hit_data = '0;
		victim_tag = '0;
		victim_data = '0;
		for (int i = 0; i < mem_system_pkg::NUM_WAYS; i++) begin
			if (hit_mask[i]) begin
				hit_data = words[i];
			end
			if (chosen_way[i]) begin
				victim_tag = tags[i]; // Used for the writeback address
				victim_data = words[i];
			end
		end
	end

endmodule

// ==== verification/mem_system_checker.sv ====
`timescale 1ns/100ps

module mem_system_checker (
	input logic clk,
	input logic reset,
	input mem_system_pkg::addr_t addr,
	input mem_system_pkg::word_t data_in,
	input logic rd,
	input logic wr,
	input mem_system_pkg::word_t data_out,
	input logic done,
	input logic stall,
	input logic cache_hit,
	input logic err,
	input logic report,
	output int error_count
);

	mem_system_pkg::word_t image [mem_system_pkg::MEM_WORDS]; // Last value written per word
	mem_system_pkg::tag_t set_tag [mem_system_pkg::NUM_SETS][mem_system_pkg::NUM_WAYS];
	mem_system_pkg::way_mask_t set_valid [mem_system_pkg::NUM_SETS];
	mem_system_pkg::way_mask_t set_dirty [mem_system_pkg::NUM_SETS];
	logic victim; // One replacement bit for the whole cache
	logic pending;
	logic exp_err;
	logic exp_hit;
	logic exp_read;
	mem_system_pkg::word_t exp_data;
	mem_system_pkg::addr_t req_addr;
	int exp_cycles;
	int cycles;
	int errors = 0;
	int requests = 0;
	int hits = 0;
	int clean_misses = 0;
	int dirty_misses = 0;
	int odd_requests = 0;

	assign error_count = errors;

	task automatic predict(input mem_system_pkg::addr_t a, input mem_system_pkg::word_t d,
		input logic is_wr);
		mem_system_pkg::index_t idx;
		int way;
		idx = a[10:3];
		requests++;
		pending = 1'b1;
		cycles = 0;
		req_addr = a;
		exp_read = !is_wr;
		exp_err = a[0];
		exp_hit = 1'b0;
		exp_cycles = 1;
		if (exp_err) begin
			odd_requests++; // Nothing in the cache moves
		end else begin
			way = -1;
			for (int w = 0; w < mem_system_pkg::NUM_WAYS; w++) begin
				if (set_valid[idx][w] && set_tag[idx][w] == a[15:11]) way = w;
			end
			victim = !victim; // Flips on every compare
			if (way >= 0) begin
				exp_hit = 1'b1;
				hits++;
			end else begin
				if (!set_valid[idx][0]) way = 0;
				else if (!set_valid[idx][1]) way = 1;
				else way = victim ? 1 : 0;
				if (set_valid[idx][way] && set_dirty[idx][way]) begin
					exp_cycles = 13; // Four writebacks first
					dirty_misses++;
				end else begin
					exp_cycles = 9;
					clean_misses++;
				end
				set_tag[idx][way] = a[15:11];
				set_valid[idx][way] = 1'b1;
				set_dirty[idx][way] = 1'b0;
			end
			exp_data = image[a[15:1]];
			if (is_wr) begin
				image[a[15:1]] = d;
				set_dirty[idx][way] = 1'b1;
			end
		end
	endtask

	task automatic check_completion();
		if (cycles != exp_cycles) begin
			errors++;
			$display("error done latency: expected 0x%0h cycles, got 0x%0h (addr 0x%h)",
				exp_cycles, cycles, req_addr);
		end
		if (err !== exp_err) begin
			errors++;
			$display("error err: expected 0x%h, got 0x%h (addr 0x%h)", exp_err, err, req_addr);
		end
		if (cache_hit !== exp_hit) begin
			errors++;
			$display("error cache_hit: expected 0x%h, got 0x%h (addr 0x%h)",
				exp_hit, cache_hit, req_addr);
		end
		if (exp_read && !exp_err && data_out !== exp_data) begin
			errors++;
			$display("error data_out: expected 0x%h, got 0x%h (addr 0x%h)",
				exp_data, data_out, req_addr);
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < mem_system_pkg::MEM_WORDS; i++) begin
				image[i] = '0;
			end
			for (int s = 0; s < mem_system_pkg::NUM_SETS; s++) begin
				set_valid[s] = '0;
				set_dirty[s] = '0;
			end
			victim = 1'b0;
			pending = 1'b0;
		end else if (pending) begin
			cycles++;
			if (done) begin
				check_completion();
				pending = 1'b0;
			end
		end else if (done) begin
			errors++;
			$display("done pulsed while no request was outstanding");
		end else if ((rd || wr) && !stall) begin
			predict(addr, data_in, wr);
		end
	end

	always @(posedge report) begin
		$write("checker: %0d requests, %0d hits, %0d clean misses, ",
			requests, hits, clean_misses);
		$display("%0d dirty misses, %0d odd, %0d errors",
			dirty_misses, odd_requests, errors);
	end

endmodule

// ==== verification/mem_system_sva.sv ====
`timescale 1ns/100ps

module mem_system_sva (
	input logic clk,
	input logic reset,
	input logic rd,
	input logic wr,
	input logic done,
	input logic stall,
	input logic cache_hit,
	input logic err,
	input mem_system_pkg::word_t data_out
);

	done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for a second cycle");
	err_pulse: assert property (@(posedge clk) disable iff (reset) err |=> !err)
		else $error("err stayed high for a second cycle");
	err_with_done: assert property (@(posedge clk) disable iff (reset) err |-> done)
		else $error("err raised without done");
	stall_on_accept: assert property (@(posedge clk) disable iff (reset)
		(rd || wr) && !stall |=> stall)
		else $error("stall did not rise after an accepted request");
	stall_until_done: assert property (@(posedge clk) disable iff (reset) stall && !done |=> stall)
		else $error("stall dropped before done");
	quiet_after_reset: assert property (@(posedge clk)
		reset |=> !done && !stall && !cache_hit && !err && data_out == '0)
		else $error("outputs not low after reset");

endmodule

// ==== verification/mem_system_tb.sv ====
`timescale 1ns/100ps

module mem_system_tb;

	localparam int NUM_REQUESTS = 400;
	localparam int DONE_LIMIT = 30; // Longest access is 13 cycles
	localparam int IDLE_LIMIT = 30;
	localparam mem_system_pkg::tag_t TAGS [4] = '{5'h01, 5'h0a, 5'h13, 5'h1e};
	localparam mem_system_pkg::index_t INDEXES [3] = '{8'h00, 8'h2c, 8'hf1};

	logic clk = 1'b0;
	logic reset;
	mem_system_pkg::addr_t addr;
	mem_system_pkg::word_t data_in;
	logic rd;
	logic wr;
	mem_system_pkg::word_t data_out;
	logic done;
	logic stall;
	logic cache_hit;
	logic err;
	logic report;
	logic timed_out;
	int error_count;
	int seed;

	always #20 clk = ~clk;

	mem_system u_mem_system (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err)
	);

	mem_system_checker u_checker (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err),
		.report(report),
		.error_count(error_count)
	);

	bind mem_system mem_system_sva u_sva (
		.clk(clk),
		.reset(reset),
		.rd(rd),
		.wr(wr),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err),
		.data_out(data_out)
	);

	// Few tags over few sets, so conflicts and dirty evictions are common
	task automatic make_request(output mem_system_pkg::addr_t a, output mem_system_pkg::word_t d,
		output logic is_wr);
		mem_system_pkg::tag_t tag;
		mem_system_pkg::index_t index;
		logic [1:0] word;
		tag = TAGS[$unsigned($random(seed)) % 4];
		if ($unsigned($random(seed)) % 8 == 0) index = 8'($random(seed)); // Far set
		else index = INDEXES[$unsigned($random(seed)) % 3];
		word = 2'($random(seed));
		a = {tag, index, word, 1'b0};
		if ($unsigned($random(seed)) % 25 == 0) a[0] = 1'b1; // Odd address
		d = 16'($random(seed));
		is_wr = 1'($random(seed));
	endtask

	task automatic run_request(input mem_system_pkg::addr_t a, input mem_system_pkg::word_t d,
		input logic is_wr);
		int cycles;
		cycles = 0;
		while (stall && cycles < IDLE_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (stall) begin
			$display("timeout: stall stayed high with no request outstanding");
			timed_out = 1'b1;
		end else begin
			addr = a;
			data_in = d;
			rd = !is_wr;
			wr = is_wr;
			@(negedge clk); // Accepted on the edge just passed
			rd = 1'b0;
			wr = 1'b0;
			cycles = 1;
			while (!done && cycles < DONE_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			if (!done) begin
				$display("timeout: no done within %0d cycles of request to 0x%h", DONE_LIMIT, a);
				timed_out = 1'b1;
			end else begin
				@(negedge clk); // Controller back in idle
			end
		end
	endtask

	initial begin
		mem_system_pkg::addr_t req_addr;
		mem_system_pkg::word_t req_data;
		logic req_wr;
		seed = 32'h4cddaba1;
		reset = 1'b1;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		report = 1'b0;
		timed_out = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int n = 0; n < NUM_REQUESTS && !timed_out; n++) begin
			make_request(req_addr, req_data, req_wr);
			run_request(req_addr, req_data, req_wr);
			if ($unsigned($random(seed)) % 4 == 0) @(negedge clk); // Idle gap
		end
		report = 1'b1;
		#1;
		if (error_count == 0 && !timed_out) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
source/mem_system_pkg.sv
source/cache_if.sv
source/cache_way.sv
source/way_select.sv
source/cache_controller.sv
source/main_memory.sv
source/mem_system.sv
verification/mem_system_sva.sv
verification/mem_system_checker.sv
verification/mem_system_tb.sv
